//--- list.f
+incdir+bench
source/fpalu_pkg.sv
source/align_stage.sv
source/booth_mul_stage.sv
source/unified_sum.sv
source/result_normalize.sv
source/fpalu_top.sv
bench/tb_clock.sv
bench/tb_fpalu.sv

//--- run_sim.sh
#!/bin/sh
# Build the FPALU testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	-f list.f --top-module tb_fpalu -Mdir "$BUILD_DIR" -o tb_fpalu
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/tb_fpalu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "tests failed" "$LOG"; then
	echo "Simulation reported a failure, see $LOG"
	exit 1
fi

echo "Simulation finished without failures"
exit 0

//--- bench/tb_fpalu_checks.svh
// FPALU testbench reference model, input drivers and result compares
`ifndef TB_FPALU_CHECKS_SVH
`define TB_FPALU_CHECKS_SVH

	// Exact FP16 product, each operand taken from its value formula
	function automatic fpalu_pkg::fp_operand_t ref_mul16(
		input fpalu_pkg::fp_operand_t x,
		input fpalu_pkg::fp_operand_t z
	);
		fpalu_pkg::fp_operand_t r;
		longint mx, mz, p;
		int     ex, ez, top, e;
		ex = x.exp[fpalu_pkg::FP16_EXP_W-1:0];
		ez = z.exp[fpalu_pkg::FP16_EXP_W-1:0];
		mx = (ex == 0) ? x.man[9:0] : (1 << fpalu_pkg::FP16_FRAC_W) + x.man[9:0];
		mz = (ez == 0) ? z.man[9:0] : (1 << fpalu_pkg::FP16_FRAC_W) + z.man[9:0];
		if (ex == 0) ex = 1; // frac * 2^-24 is frac * 2^(1 - 25)
		if (ez == 0) ez = 1;
		p = mx * mz; // Never more than 22 bits
		r = '0;
		if (p != 0) begin
			top = fpalu_pkg::FP29_MAN_W - 1;
			while (p[top] == 1'b0) top--;
			p = p << (fpalu_pkg::FP29_MAN_W - 1 - top); // Top one to bit 21
			// p * 2^(ex + ez - 50) rewritten as man * 2^(e - 53)
			e = ex + ez - 2 * (fpalu_pkg::FP16_BIAS + fpalu_pkg::FP16_FRAC_W)
				+ (fpalu_pkg::FP29_BIAS + fpalu_pkg::FP29_MAN_W) - (fpalu_pkg::FP29_MAN_W - 1 - top);
			r.sgn = x.sgn ^ z.sgn;
			r.man = p[fpalu_pkg::FP29_MAN_W-1:0];
			r.exp = e[fpalu_pkg::FP29_EXP_W-1:0];
		end
		return r;
	endfunction

	// Sum of FP29i values, l is the left (larger) operand
	function automatic fpalu_pkg::fp_operand_t ref_add29(
		input fpalu_pkg::fp_operand_t l,
		input fpalu_pkg::fp_operand_t r
	);
		fpalu_pkg::fp_operand_t res;
		longint rm, s;
		int     d, e;
		d   = int'(l.exp) - int'(r.exp);
		rm  = (d >= fpalu_pkg::FP29_MAN_W) ? 0 : (longint'(r.man) >> d); // Lost bits dropped
		s   = (l.sgn == r.sgn) ? longint'(l.man) + rm : longint'(l.man) - rm;
		e   = l.exp;
		res = '0;
		if (s != 0) begin
			if (s >= (longint'(1) << fpalu_pkg::FP29_MAN_W)) begin
				s = s >> 1; // Carry, low bit truncated
				e++;
			end
			while (s < (longint'(1) << (fpalu_pkg::FP29_MAN_W - 1))) begin
				s = s << 1;
				e--;
			end
			res.sgn = l.sgn;
			res.man = s[fpalu_pkg::FP29_MAN_W-1:0];
			res.exp = e[fpalu_pkg::FP29_EXP_W-1:0];
		end
		return res;
	endfunction

	// Random FP16 in a 29-bit operand, ignored fields left random too
	function automatic fpalu_pkg::fp_operand_t rand_fp16(input bit sub, input int e_lo, e_hi);
		fpalu_pkg::fp_operand_t r;
		r.sgn      = 1'($urandom);
		r.exp      = 6'($urandom);
		r.man      = 22'($urandom);
		r.exp[4:0] = sub ? 5'd0 : 5'($urandom_range(e_hi, e_lo));
		return r;
	endfunction

	// Random normalized FP29i with a given exponent
	function automatic fpalu_pkg::fp_operand_t rand_fp29(input int e);
		fpalu_pkg::fp_operand_t r;
		r.sgn = 1'($urandom);
		r.exp = 6'(e);
		r.man = {1'b1, 21'($urandom)};
		return r;
	endfunction

	// Larger exponent, then larger man, goes left; zero always right
	function automatic bit left_first(input fpalu_pkg::fp_operand_t p, q);
		if (q.man == '0) return 1'b1;
		if (p.man == '0) return 1'b0;
		return (p.exp > q.exp) || ((p.exp == q.exp) && (p.man >= q.man));
	endfunction

	task automatic drive_inputs(
		input fpalu_pkg::fpalu_op_e   o,
		input fpalu_pkg::fp_operand_t x,
		input fpalu_pkg::fp_operand_t z
	);
		@(posedge clk);
		op <= o;
		a  <= x;
		b  <= z;
	endtask

	// Drive one op and queue its expected result
	task automatic send_op(
		input fpalu_pkg::fpalu_op_e   o,
		input fpalu_pkg::fp_operand_t x,
		input fpalu_pkg::fp_operand_t z
	);
		drive_inputs(o, x, z);
		if (o == fpalu_pkg::OP_MUL16) expect_q.push_back(ref_mul16(x, z));
		else if (o == fpalu_pkg::OP_ADD29) expect_q.push_back(ref_add29(x, z));
	endtask

	task automatic send_add29(input fpalu_pkg::fp_operand_t p, q);
		if (left_first(p, q)) send_op(fpalu_pkg::OP_ADD29, p, q);
		else send_op(fpalu_pkg::OP_ADD29, q, p);
	endtask

	task automatic check_operand(input string name, input fpalu_pkg::fp_operand_t want, got);
		if (got !== want) begin
			$display("Fail %s expected sgn %0b exp %0d man %06h, actual sgn %0b exp %0d man %06h",
				name, want.sgn, want.exp, want.man, got.sgn, got.exp, got.man);
			test_errors++;
		end
	endtask

	task automatic check_valid_count(input string name, input int want, got);
		if (got != want) begin
			$display("Fail %s expected %0d y_valid pulses, actual %0d", name, want, got);
			test_errors++;
		end
	endtask

	task automatic check_latency(input string name, input int want, got);
		if (got != want) begin
			$display("Fail %s expected latency %0d cycles, actual %0d", name, want, got);
			test_errors++;
		end
	endtask

	// Idle the inputs until every queued result is out, bounded
	task automatic drain_pipe();
		int waited;
		waited = 0;
		while (expect_q.size() != 0 && waited < DRAIN_MAX) begin
			drive_inputs(fpalu_pkg::OP_IDLE, '0, '0);
			waited++;
		end
		if (expect_q.size() != 0) begin
			$display("%s: %0d results never came out of the pipe", cur_test, expect_q.size());
			test_errors++;
			expect_q.delete();
		end
	endtask

	task automatic begin_test(input string name);
		cur_test    = name;
		test_errors = 0;
		pulses      = 0;
	endtask

	task automatic end_test(input int want_pulses);
		drain_pipe();
		check_valid_count(cur_test, want_pulses, pulses);
		tests_run++;
		total_errors += test_errors;
		if (test_errors == 0) begin
			$display("%s: ok", cur_test);
		end else begin
			tests_bad++;
			$display("%s: %0d errors", cur_test, test_errors);
		end
	endtask

`endif

//--- bench/tb_fpalu.sv
// FPALU testbench top running directed multiply, add and mixed stream tests
`timescale 1ns/100ps

module tb_fpalu;

	localparam int CLK_NS    = 40;
	localparam int N_IDLE    = 12;
	localparam int N_MUL     = 48;
	localparam int N_ADD     = 50;
	localparam int N_SUB     = 32;
	localparam int N_ZERO    = 12;
	localparam int N_MIX     = 64;
	localparam int N_TESTS   = 6;
	localparam int DRAIN_MAX = 12; // Pipe empties in about six
	localparam int TOTAL_OPS = N_IDLE + 2 + N_MUL + N_ADD + N_SUB + N_ZERO + N_MIX
		+ N_TESTS * DRAIN_MAX;

	localparam fpalu_pkg::fp_operand_t ZERO = '0;

	logic                   clk, arst_n;
	fpalu_pkg::fpalu_op_e   op;
	fpalu_pkg::fp_operand_t a, b, y, want;
	logic                   y_valid;

	fpalu_pkg::fp_operand_t expect_q[$]; // Results in issue order
	string cur_test = "reset";
	int    cycle = 0, valid_cycle = 0, pulses = 0;
	int    test_errors = 0, total_errors = 0, tests_run = 0, tests_bad = 0;

	`include "tb_fpalu_checks.svh"

	tb_clock tb_clock_i (.clk(clk), .arst_n(arst_n));

	fpalu_top fpalu_top_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.op      (op),
		.a       (a),
		.b       (b),
		.y       (y),
		.y_valid (y_valid)
	);

	always @(posedge clk) cycle <= cycle + 1;

	// Outputs sampled mid-cycle away from the edge
	always @(negedge clk) begin
		if (arst_n && y_valid) begin
			pulses++;
			valid_cycle = cycle;
			if (expect_q.size() == 0) begin
				$display("%s: a result came out with nothing in flight", cur_test);
				test_errors++;
			end else begin
				want = expect_q.pop_front();
				check_operand(cur_test, want, y);
			end
		end
	end

	task automatic reset_idle_test();
		int t0;
		begin_test("reset_idle");
		repeat (N_IDLE) drive_inputs(fpalu_pkg::OP_IDLE, ZERO, ZERO);
		check_valid_count("reset_idle idle run", 0, pulses);
		send_op(fpalu_pkg::OP_ADD29, rand_fp29(40), ZERO);
		@(negedge clk);
		t0 = cycle; // Sampling edge is the next one
		drain_pipe();
		check_latency("reset_idle", 4, valid_cycle - (t0 + 1));
		end_test(1);
	endtask

	task automatic mul16_test();
		fpalu_pkg::fp_operand_t x, z;
		bit sub_x, sub_z;
		begin_test("mul16");
		for (int i = 0; i < N_MUL; i++) begin
			sub_x = (i % 4 == 2);
			sub_z = (i % 4 == 3);
			x = rand_fp16(sub_x, sub_z ? 8 : 1, 30); // Subnormal partner needs e >= 8
			z = rand_fp16(sub_z, sub_x ? 8 : 1, 30);
			send_op(fpalu_pkg::OP_MUL16, x, z);
		end
		x          = rand_fp16(1'b1, 0, 0);
		x.sgn      = 1'b1; // Negative zero still gives canonical zero
		x.man[9:0] = '0;
		send_op(fpalu_pkg::OP_MUL16, x, rand_fp16(1'b0, 1, 30));
		end_test(N_MUL + 1);
	endtask

	task automatic add_same_sign_test();
		fpalu_pkg::fp_operand_t x, z;
		int gap;
		begin_test("add29_same_sign");
		for (int i = 0; i < N_ADD; i++) begin
			case (i % 5)
				0: gap = 0; // Always carries
				1: gap = 1;
				2: gap = 21;
				3: gap = 22;
				default: gap = $urandom_range(40, 23);
			endcase
			x     = rand_fp29($urandom_range(62, 41));
			z     = rand_fp29(x.exp - gap);
			z.sgn = x.sgn;
			send_add29(x, z);
		end
		end_test(N_ADD);
	endtask

	task automatic sub_cancel_test();
		fpalu_pkg::fp_operand_t x, z;
		begin_test("add29_subtract");
		for (int i = 0; i < N_SUB; i++) begin
			x = rand_fp29($urandom_range(62, 30)); // Room for a 21-bit left shift
			case (i % 4)
				0: z = rand_fp29(x.exp);
				1: z = rand_fp29(x.exp - 1);
				2: z = rand_fp29(x.exp - $urandom_range(30, 2));
				default: z = x; // Equal magnitudes cancel
			endcase
			z.sgn = ~x.sgn;
			send_add29(x, z);
		end
		end_test(N_SUB);
	endtask

	task automatic zero_operand_test();
		fpalu_pkg::fp_operand_t x;
		begin_test("add29_zero");
		for (int i = 0; i < N_ZERO; i++) begin
			x = rand_fp29($urandom_range(62, 0));
			drive_inputs(fpalu_pkg::OP_ADD29, x, ZERO);
			expect_q.push_back(x); // Comes back unchanged
		end
		end_test(N_ZERO);
	endtask

	task automatic mixed_stream_test();
		fpalu_pkg::fp_operand_t x, z;
		int n;
		begin_test("mixed_stream");
		n = 0;
		for (int i = 0; i < N_MIX; i++) begin
			case ($urandom_range(2, 0))
				0: drive_inputs(fpalu_pkg::OP_IDLE, ZERO, ZERO);
				1: begin
					send_op(fpalu_pkg::OP_MUL16, rand_fp16(1'b0, 1, 30), rand_fp16(1'b0, 1, 30));
					n++;
				end
				default: begin
					x = rand_fp29($urandom_range(62, 30));
					z = rand_fp29(x.exp - $urandom_range(30, 0)); // Either sign
					send_add29(x, z);
					n++;
				end
			endcase
		end
		end_test(n);
	endtask

	// Watchdog sized from the operation count
	initial begin
		#((TOTAL_OPS + 100) * CLK_NS);
		$display("Timeout: the run went past %0d cycles", TOTAL_OPS + 100);
		$display("tests failed");
		$finish;
	end

	initial begin
		void'($urandom(32'h3846_6d1a));
		op <= fpalu_pkg::OP_IDLE;
		a  <= ZERO;
		b  <= ZERO;
		@(posedge arst_n);
		reset_idle_test();
		mul16_test();
		add_same_sign_test();
		sub_cancel_test();
		zero_operand_test();
		mixed_stream_test();
		$display("Summary: %0d run, %0d clean, %0d with errors, %0d errors in all",
			tests_run, tests_run - tests_bad, tests_bad, total_errors);
		if (total_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- bench/tb_clock.sv
// Testbench clock and reset source, 40 ns clock with a 16 cycle reset
`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic arst_n
);

	localparam int PERIOD_NS    = 40;
	localparam int RESET_CYCLES = 16;

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		arst_n = 1'b0; // Held low from time zero
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1; // Released on a rising edge like any other input
	end

endmodule

//--- source/fpalu_top.sv
// FPALU top level, five-stage FP16 multiply and FP29i add pipeline
`timescale 1ns/100ps

module fpalu_top (
	input  logic                   clk,
	input  logic                   arst_n,
	input  fpalu_pkg::fpalu_op_e   op,
	input  fpalu_pkg::fp_operand_t a,
	input  fpalu_pkg::fp_operand_t b,
	output fpalu_pkg::fp_operand_t y,
	output logic                   y_valid
);

	fpalu_pkg::add_term_t add_term; // Stage 3 add pair and op tag
	fpalu_pkg::mul_term_t mul_term; // Stage 3 partial sums
	fpalu_pkg::sum_t      sum;      // Stage 4 raw magnitude

	align_stage align_stage_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.op       (op),
		.a        (a),
		.b        (b),
		.add_term (add_term)
	);

	booth_mul_stage booth_mul_stage_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.op       (op),
		.a        (a),
		.b        (b),
		.mul_term (mul_term)
	);

	unified_sum unified_sum_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.add_term (add_term),
		.mul_term (mul_term),
		.sum      (sum)
	);

	result_normalize result_normalize_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.sum     (sum),
		.y       (y),
		.y_valid (y_valid)
	);

endmodule

//--- source/result_normalize.sv
// Stages 4 and 5, leading-zero count and normalization of the raw sum
`timescale 1ns/100ps

module result_normalize (
	input  logic                   clk,
	input  logic                   arst_n,
	input  fpalu_pkg::sum_t        sum,
	output fpalu_pkg::fp_operand_t y,
	output logic                   y_valid
);

	typedef logic [fpalu_pkg::LZC_W-1:0] lzc_t;
	typedef logic [fpalu_pkg::SUM_W-1:0] mag_t;

	lzc_t                lz, lz_s4;
	mag_t                mag_s4, norm;
	logic                sgn_s4, valid_s4;
	logic                is_zero;
	fpalu_pkg::exp_ext_t exp_s4, exp_fin;

	// All zeros counts as the full width
	function automatic lzc_t lead_zeros(input mag_t v);
		lzc_t n;
		logic found;
		n     = lzc_t'(fpalu_pkg::SUM_W);
		found = 1'b0;
		for (int i = fpalu_pkg::SUM_W - 1; i >= 0; i--) begin
			if (!found && v[i]) begin
				n     = lzc_t'(fpalu_pkg::SUM_W - 1 - i);
				found = 1'b1;
			end
		end
		return n;
	endfunction

	// Stage 4
	assign lz = lead_zeros(sum.mag);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_s4 <= 1'b0;
		end else begin
			valid_s4 <= (sum.op != fpalu_pkg::OP_IDLE);
		end
	end

	always_ff @(posedge clk) begin
		mag_s4 <= sum.mag;
		lz_s4  <= lz;
		sgn_s4 <= sum.sgn;
		exp_s4 <= sum.exp;
	end

	// Stage 5, top one to bit 22, bit 0 dropped
	assign norm    = mag_s4 << lz_s4;
	assign is_zero = (mag_s4 == '0);
	assign exp_fin = exp_s4 - fpalu_pkg::exp_ext_t'(lz_s4);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			y_valid <= 1'b0;
		end else begin
			y_valid <= valid_s4;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_s4) begin // Hold last result across bubbles
			y.sgn <= is_zero ? 1'b0 : sgn_s4;
			y.exp <= is_zero ? '0 : exp_fin[fpalu_pkg::FP29_EXP_W-1:0]; // Wraps out of range
			y.man <= norm[fpalu_pkg::SUM_W-1:1];
		end
	end

	// Every result leaves normalized or as the canonical zero
	a_normalized: assert property (@(posedge clk) disable iff (!arst_n)
		y_valid |-> (y.man[fpalu_pkg::FP29_MAN_W-1] || (y == '0)));

endmodule

//--- source/unified_sum.sv
// Stage 3 shared mantissa adder for add and multiply terms
`timescale 1ns/100ps

module unified_sum (
	input  logic                 clk,
	input  logic                 arst_n,
	input  fpalu_pkg::add_term_t add_term,
	input  fpalu_pkg::mul_term_t mul_term,
	output fpalu_pkg::sum_t      sum
);

	logic                        is_mul;
	logic [fpalu_pkg::SUM_W-1:0] lhs, rhs, mag, mag_q;
	logic                        cin;
	logic [fpalu_pkg::SUM_W:0]   total; // With carry out
	logic                        sgn_q;
	fpalu_pkg::exp_ext_t         exp_q;
	fpalu_pkg::fpalu_op_e        op_q;

	assign is_mul = (add_term.op == fpalu_pkg::OP_MUL16);

	always_comb begin
		if (is_mul) begin
			lhs = {{(fpalu_pkg::SUM_W - fpalu_pkg::PS0_W){1'b0}}, mul_term.ps0};
			rhs = {1'b0, mul_term.ps1, 1'b0, mul_term.corr, 4'b0000}; // ps1 at 2^6, corr at 2^4
			cin = 1'b0;
		end else begin
			lhs = add_term.lhs;
			rhs = add_term.rhs;
			cin = add_term.sub; // Completes the two's complement
		end
	end

	assign total = {1'b0, lhs} + {1'b0, rhs} + {{fpalu_pkg::SUM_W{1'b0}}, cin};
	assign mag   = is_mul ? {1'b0, total[fpalu_pkg::SUM_W-2:0]} : total[fpalu_pkg::SUM_W-1:0];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op_q <= fpalu_pkg::OP_IDLE;
		end else begin
			op_q <= add_term.op;
		end
	end

	always_ff @(posedge clk) begin
		mag_q <= mag;
		sgn_q <= is_mul ? mul_term.sgn : add_term.sgn;
		exp_q <= is_mul ? mul_term.exp : add_term.exp;
	end

	assign sum = '{op: op_q, mag: mag_q, sgn: sgn_q, exp: exp_q};

	// Operand order upstream keeps every difference non-negative
	a_no_borrow: assert property (@(posedge clk) disable iff (!arst_n)
		(add_term.op == fpalu_pkg::OP_ADD29 && add_term.sub) |-> total[fpalu_pkg::SUM_W]);

endmodule

//--- source/booth_mul_stage.sv
// FP16 multiply stages 1 and 2, radix-4 Booth partial products and partial sums
`timescale 1ns/100ps

module booth_mul_stage (
	input  logic                   clk,
	input  logic                   arst_n,
	input  fpalu_pkg::fpalu_op_e   op,
	input  fpalu_pkg::fp_operand_t a,
	input  fpalu_pkg::fp_operand_t b,
	output fpalu_pkg::mul_term_t   mul_term
);

	typedef logic [fpalu_pkg::PP_W-1:0] pp_t;

	typedef struct packed {
		logic [fpalu_pkg::FP16_EXP_W-1:0] e; // Effective exponent
		logic [fpalu_pkg::FP16_MAN_W-1:0] m; // Integer significand
	} fp16_t;

	fp16_t ua, ub;
	logic [2*fpalu_pkg::BOOTH_DIGITS+1:0] mb_ext;
	pp_t  pp_s1 [fpalu_pkg::BOOTH_DIGITS];
	pp_t  pp_s2 [fpalu_pkg::BOOTH_DIGITS];
	logic [fpalu_pkg::BOOTH_DIGITS-1:0] neg_s1;
	logic [fpalu_pkg::BOOTH_DIGITS-2:0] neg_s2; // Top digit is never negative
	logic sgn_s2;
	logic mul_s2;                               // Stage 2 holds a multiply
	fpalu_pkg::exp_ext_t exp_s1, exp_s2;
	logic [fpalu_pkg::PS0_W-1:0] ps0;
	logic [fpalu_pkg::PS1_W-1:0] ps1;

	// Subnormal reads as exponent 1 without the hidden one
	function automatic fp16_t unpack(input fpalu_pkg::fp_operand_t x);
		fp16_t u;
		u.m = {x.exp[fpalu_pkg::FP16_EXP_W-1:0] != '0, x.man[fpalu_pkg::FP16_FRAC_W-1:0]};
		u.e = (x.exp[fpalu_pkg::FP16_EXP_W-1:0] == '0) ? 1 : x.exp[fpalu_pkg::FP16_EXP_W-1:0];
		return u;
	endfunction

	// Returns {neg, pp}, negative digits as one's complement
	function automatic logic [fpalu_pkg::PP_W:0] booth_digit(
		input logic [fpalu_pkg::FP16_MAN_W-1:0] m,
		input logic [2:0]                       grp
	);
		pp_t  mag;
		logic neg;
		case (grp)
			3'b001, 3'b010, 3'b101, 3'b110: mag = {1'b0, m}; // +-1
			3'b011, 3'b100:                 mag = {m, 1'b0}; // +-2
			default:                        mag = '0;
		endcase
		neg = grp[2] & ~(grp[1] & grp[0]); // 111 is zero, not minus zero
		return {neg, neg ? ~mag : mag};
	endfunction

	assign ua     = unpack(a);
	assign ub     = unpack(b);
	assign mb_ext = {2'b00, ub.m, 1'b0};
	assign exp_s1 = fpalu_pkg::exp_ext_t'(ua.e) + fpalu_pkg::exp_ext_t'(ub.e)
		+ fpalu_pkg::exp_ext_t'(fpalu_pkg::MUL_EXP_ADJ);

	always_comb begin
		for (int i = 0; i < fpalu_pkg::BOOTH_DIGITS; i++) begin
			{neg_s1[i], pp_s1[i]} = booth_digit(ua.m, mb_ext[2*i +: 3]);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mul_s2 <= 1'b0;
		end else begin
			mul_s2 <= (op == fpalu_pkg::OP_MUL16);
		end
	end

	// Operands held while no multiply is in flight
	always_ff @(posedge clk) begin
		if (op == fpalu_pkg::OP_MUL16) begin
			pp_s2  <= pp_s1;
			neg_s2 <= neg_s1[fpalu_pkg::BOOTH_DIGITS-2:0];
			sgn_s2 <= a.sgn ^ b.sgn;
			exp_s2 <= exp_s1;
		end
	end

	// Sign extension folded into constant ones, sums wrap at 2^22
	always_comb begin
		ps0 = fpalu_pkg::PS0_W'({~neg_s2[0], neg_s2[0], neg_s2[0], pp_s2[0]})
			+ fpalu_pkg::PS0_W'({1'b1, ~neg_s2[1], pp_s2[1], 1'b0, neg_s2[0]})
			+ fpalu_pkg::PS0_W'({1'b1, ~neg_s2[2], pp_s2[2], 1'b0, neg_s2[1], 2'b00});
		ps1 = fpalu_pkg::PS1_W'({1'b1, ~neg_s2[3], pp_s2[3]})
			+ fpalu_pkg::PS1_W'({1'b1, ~neg_s2[4], pp_s2[4], 1'b0, neg_s2[3]})
			+ fpalu_pkg::PS1_W'({pp_s2[5], 1'b0, neg_s2[4], 2'b00});
	end

	always_ff @(posedge clk) begin
		if (mul_s2) begin
			mul_term <= '{ps0: ps0, ps1: ps1, corr: neg_s2[2], sgn: sgn_s2, exp: exp_s2};
		end
	end

endmodule

//--- source/align_stage.sv
// FP29i add path stages 1 and 2 for operand ordering and mantissa alignment
`timescale 1ns/100ps

module align_stage (
	input  logic                   clk,
	input  logic                   arst_n,
	input  fpalu_pkg::fpalu_op_e   op,
	input  fpalu_pkg::fp_operand_t a,
	input  fpalu_pkg::fp_operand_t b,
	output fpalu_pkg::add_term_t   add_term
);

	typedef logic [fpalu_pkg::FP29_EXP_W-1:0] exp_t;
	typedef logic [fpalu_pkg::FP29_MAN_W-1:0] man_t;
	typedef logic [fpalu_pkg::SUM_W-1:0]      sum_w_t;

	typedef struct packed {
		logic sgn;   // Sign of the larger operand
		logic sub;   // Signs differ
		exp_t l_exp;
		exp_t r_exp;
		man_t l_man;
		man_t r_man;
	} order_t;

	logic   a_zero, b_zero, a_ge_b;
	order_t ord, ord_s2;
	fpalu_pkg::fpalu_op_e op_s2, op_s3;

	exp_t                diff;
	man_t                aligned;
	sum_w_t              lhs, rhs, lhs_q, rhs_q;
	logic                sub_q, sgn_q;
	fpalu_pkg::exp_ext_t exp_nxt, exp_q;

	// Stage 1 magnitude compare with zero always smallest
	assign a_zero = (a.man == '0);
	assign b_zero = (b.man == '0);
	assign a_ge_b = b_zero || (!a_zero && ({a.exp, a.man} >= {b.exp, b.man}));

	always_comb begin
		ord.sgn   = a_ge_b ? a.sgn : b.sgn;
		ord.sub   = a.sgn ^ b.sgn;
		ord.l_exp = a_ge_b ? a.exp : b.exp; // Larger goes left
		ord.r_exp = a_ge_b ? b.exp : a.exp;
		ord.l_man = a_ge_b ? a.man : b.man;
		ord.r_man = a_ge_b ? b.man : a.man;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op_s2 <= fpalu_pkg::OP_IDLE;
		end else begin
			op_s2 <= op;
		end
	end

	always_ff @(posedge clk) begin
		ord_s2 <= ord;
	end

	// Stage 2 truncating right shift of the smaller mantissa
	assign diff    = ord_s2.l_exp - ord_s2.r_exp; // Non-negative unless right is zero
	assign aligned = (diff >= exp_t'(fpalu_pkg::FP29_MAN_W)) ? '0 : (ord_s2.r_man >> diff);
	assign lhs     = {1'b0, ord_s2.l_man};
	assign rhs     = {1'b0, aligned} ^ {fpalu_pkg::SUM_W{ord_s2.sub}}; // One's complement
	assign exp_nxt = fpalu_pkg::exp_ext_t'(ord_s2.l_exp) + 1'b1;        // Carry bit weight

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op_s3 <= fpalu_pkg::OP_IDLE;
		end else begin
			op_s3 <= op_s2;
		end
	end

	always_ff @(posedge clk) begin
		lhs_q <= lhs;
		rhs_q <= rhs;
		sub_q <= ord_s2.sub;
		sgn_q <= ord_s2.sgn;
		exp_q <= exp_nxt;
	end

	assign add_term = '{op: op_s3, lhs: lhs_q, rhs: rhs_q, sub: sub_q, sgn: sgn_q, exp: exp_q};

	// Aligned right mantissa never exceeds the left one for normalized inputs
	a_left_larger: assert property (@(posedge clk) disable iff (!arst_n)
		(op_s2 == fpalu_pkg::OP_ADD29) |-> (ord_s2.l_man >= aligned));

endmodule

//--- source/fpalu_pkg.sv
// FPALU shared definitions: number formats, opcodes and pipeline stage records
package fpalu_pkg;

	// FP16 operand fields, value (1024 + frac) * 2^(e - 25)
	localparam int FP16_EXP_W  = 5;
	localparam int FP16_FRAC_W = 10;
	localparam int FP16_BIAS   = 15;
	localparam int FP16_MAN_W  = FP16_FRAC_W + 1; // With hidden one

	// FP29i fields, value man * 2^(exp - 53)
	localparam int FP29_EXP_W = 6;
	localparam int FP29_MAN_W = 22;
	localparam int FP29_BIAS  = 31;

	localparam int SUM_W = FP29_MAN_W + 1; // Mantissa plus carry

	// Booth radix-4 multiplier geometry
	localparam int BOOTH_DIGITS = 6;              // 11-bit multiplier plus zero pad
	localparam int PP_W         = FP16_MAN_W + 1; // Room for 2x multiplicand
	localparam int PS0_W        = 19;             // Digits 0..2
	localparam int PS1_W        = 16;             // Digits 3..5, weight 2^6

	localparam int LZC_W = 5; // Counts 0..23

	// Product exponent offset
	// 22-bit product sits at mag weight 2^(ea + eb - 50), mag weight is 2^(exp - 54)
	localparam int MUL_EXP_ADJ = FP29_BIAS - 2 * FP16_BIAS + 3;

	typedef enum logic [1:0] {
		OP_IDLE  = 2'b00, // Bubble, no result
		OP_MUL16 = 2'b10,
		OP_ADD29 = 2'b11
	} fpalu_op_e;

	typedef struct packed {
		logic                  sgn;
		logic [FP29_EXP_W-1:0] exp;
		logic [FP29_MAN_W-1:0] man;
	} fp_operand_t;

	// One spare bit so the exponent can dip or carry before final truncation
	typedef logic signed [FP29_EXP_W:0] exp_ext_t;

	typedef struct packed {
		fpalu_op_e        op;  // Tag for the whole pipe
		logic [SUM_W-1:0] lhs;
		logic [SUM_W-1:0] rhs; // Inverted when sub
		logic             sub; // Also the carry-in
		logic             sgn;
		exp_ext_t         exp;
	} add_term_t;

	typedef struct packed {
		logic [PS0_W-1:0] ps0;
		logic [PS1_W-1:0] ps1;
		logic             corr; // Sign bit of digit 2
		logic             sgn;
		exp_ext_t         exp;
	} mul_term_t;

	typedef struct packed {
		fpalu_op_e        op;
		logic [SUM_W-1:0] mag;
		logic             sgn;
		exp_ext_t         exp;
	} sum_t;

endpackage
